// File: source/axi2apb_pkg.sv
package axi2apb_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // AR and AW payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        prot;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

    // One APB transfer as requested by an engine
    typedef struct packed {
        logic              write;
        logic [2:0]        prot;
        logic [STRB_W-1:0] strb;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } apb_cmd_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
        logic [2:0]        pprot;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              slverr;
    } apb_result_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_ACCESS
    } apb_phase_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_RESP
    } engine_state_e;

    // Every beat of an incrementing burst is full width
    function automatic logic [ADDR_W-1:0] next_beat_addr(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] aligned;
        aligned = addr & ~ADDR_W'(STRB_W - 1);
        return aligned + ADDR_W'(STRB_W);
    endfunction

endpackage

// File: source/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine import axi2apb_pkg::*; #(
    parameter int ID_WIDTH = 8
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                i_ar_valid,
    input  axi_addr_t           i_ar,
    input  logic [ID_WIDTH-1:0] i_ar_id,
    output logic                o_ar_ready,
    output logic                o_r_valid,
    output axi_r_t              o_r,
    output logic [ID_WIDTH-1:0] o_r_id,
    input  logic                i_r_ready,
    output logic                o_cmd_valid,
    output apb_cmd_t            o_cmd,
    input  logic                i_rd_done,
    input  apb_result_t         i_result
);

    engine_state_e       r_state;
    logic [LEN_W-1:0]    r_count;
    logic [ADDR_W-1:0]   r_addr;
    logic [ID_WIDTH-1:0] r_id;
    logic [2:0]          r_prot;
    axi_r_t              r_beat;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= ST_IDLE;
            r_count <= '0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (i_ar_valid) begin
                        r_count <= i_ar.len;
                        r_state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (i_rd_done) begin
                        r_count <= r_count - 1'b1;
                        r_state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // Stall here until the master takes the beat
                    if (i_r_ready) begin
                        r_state <= r_beat.last ? ST_IDLE : ST_ISSUE;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (r_state == ST_IDLE && i_ar_valid) begin
            r_addr <= i_ar.addr & ~ADDR_W'(STRB_W - 1);
            r_id   <= i_ar_id;
            r_prot <= i_ar.prot;
        end
        if (r_state == ST_ISSUE && i_rd_done) begin
            r_addr      <= next_beat_addr(r_addr);
            r_beat.data <= i_result.rdata;
            r_beat.resp <= i_result.slverr ? SLVERR : OKAY;
            r_beat.last <= (r_count == '0);
        end
    end

    assign o_ar_ready  = (r_state == ST_IDLE);
    assign o_r_valid   = (r_state == ST_RESP);
    assign o_r         = r_beat;
    assign o_r_id      = r_id;
    assign o_cmd_valid = (r_state == ST_ISSUE);

    // Reads carry no strobes on APB
    assign o_cmd.write = 1'b0;
    assign o_cmd.prot  = r_prot;
    assign o_cmd.strb  = '0;
    assign o_cmd.addr  = r_addr;
    assign o_cmd.wdata = '0;

endmodule

// File: source/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine import axi2apb_pkg::*; #(
    parameter int ID_WIDTH = 8
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                i_aw_valid,
    input  axi_addr_t           i_aw,
    input  logic [ID_WIDTH-1:0] i_aw_id,
    output logic                o_aw_ready,
    input  logic                i_w_valid,
    input  axi_w_t              i_w,
    output logic                o_w_ready,
    output logic                o_b_valid,
    output axi_resp_e           o_b_resp,
    output logic [ID_WIDTH-1:0] o_b_id,
    input  logic                i_b_ready,
    output logic                o_cmd_valid,
    output apb_cmd_t            o_cmd,
    input  logic                i_wr_done,
    input  apb_result_t         i_result
);

    engine_state_e       r_state;
    logic [LEN_W-1:0]    r_count;
    logic                r_err;
    logic [ADDR_W-1:0]   r_addr;
    logic [ID_WIDTH-1:0] r_id;
    logic [2:0]          r_prot;
    logic [DATA_W-1:0]   r_wdata;
    logic [STRB_W-1:0]   r_strb;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= ST_IDLE;
            r_count <= '0;
            r_err   <= 1'b0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (i_aw_valid) begin
                        r_count <= i_aw.len;
                        r_err   <= 1'b0;
                        r_state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (i_w_valid) begin
                        r_state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (i_wr_done) begin
                        // Any failing beat turns the whole burst into SLVERR
                        r_err   <= r_err | i_result.slverr;
                        r_count <= r_count - 1'b1;
                        r_state <= (r_count == '0) ? ST_RESP : ST_ISSUE;
                    end
                end
                ST_RESP: begin
                    if (i_b_ready) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    // Burst length comes from AW and wlast is not consulted
    always_ff @(posedge aclk) begin
        if (r_state == ST_IDLE && i_aw_valid) begin
            r_addr <= i_aw.addr & ~ADDR_W'(STRB_W - 1);
            r_id   <= i_aw_id;
            r_prot <= i_aw.prot;
        end
        if (r_state == ST_ISSUE && i_w_valid) begin
            r_wdata <= i_w.data;
            r_strb  <= i_w.strb;
        end
        if (r_state == ST_WAIT && i_wr_done) begin
            r_addr <= next_beat_addr(r_addr);
        end
    end

    assign o_aw_ready  = (r_state == ST_IDLE);
    assign o_w_ready   = (r_state == ST_ISSUE);
    assign o_b_valid   = (r_state == ST_RESP);
    assign o_b_resp    = r_err ? SLVERR : OKAY;
    assign o_b_id      = r_id;
    assign o_cmd_valid = (r_state == ST_WAIT);

    assign o_cmd.write = 1'b1;
    assign o_cmd.prot  = r_prot;
    assign o_cmd.strb  = r_strb;
    assign o_cmd.addr  = r_addr;
    assign o_cmd.wdata = r_wdata;

endmodule

// File: source/apb_sequencer.sv
`timescale 1ns/1ps

module apb_sequencer import axi2apb_pkg::*; (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        i_rd_cmd_valid,
    input  apb_cmd_t    i_rd_cmd,
    input  logic        i_wr_cmd_valid,
    input  apb_cmd_t    i_wr_cmd,
    output apb_req_t    o_apb,
    input  apb_rsp_t    i_apb,
    output logic        o_rd_done,
    output logic        o_wr_done,
    output apb_result_t o_result
);

    apb_phase_e r_phase;
    logic       r_owner_wr;
    apb_cmd_t   r_cmd;
    logic       w_grant_rd;
    logic       w_grant_wr;
    logic       w_complete;

    // Read wins when both engines are waiting
    assign w_grant_rd = (r_phase == PH_IDLE) && i_rd_cmd_valid;
    assign w_grant_wr = (r_phase == PH_IDLE) && !i_rd_cmd_valid && i_wr_cmd_valid;
    assign w_complete = (r_phase == PH_ACCESS) && i_apb.pready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_phase    <= PH_IDLE;
            r_owner_wr <= 1'b0;
        end else begin
            case (r_phase)
                PH_IDLE: begin
                    if (w_grant_rd || w_grant_wr) begin
                        r_owner_wr <= w_grant_wr;
                        r_phase    <= PH_SETUP;
                    end
                end
                PH_SETUP: begin
                    r_phase <= PH_ACCESS;
                end
                PH_ACCESS: begin
                    // Wait states extend this phase
                    if (i_apb.pready) begin
                        r_phase <= PH_IDLE;
                    end
                end
                default: r_phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (w_grant_rd) begin
            r_cmd <= i_rd_cmd;
        end else if (w_grant_wr) begin
            r_cmd <= i_wr_cmd;
        end
    end

    assign o_apb.psel    = (r_phase != PH_IDLE);
    assign o_apb.penable = (r_phase == PH_ACCESS);
    assign o_apb.pwrite  = r_cmd.write;
    assign o_apb.paddr   = r_cmd.addr;
    assign o_apb.pwdata  = r_cmd.wdata;
    assign o_apb.pstrb   = r_cmd.strb;
    assign o_apb.pprot   = r_cmd.prot;

    // Done doubles as the acknowledge of the engine's command
    assign o_rd_done = w_complete && !r_owner_wr;
    assign o_wr_done = w_complete && r_owner_wr;

    assign o_result.rdata  = i_apb.prdata;
    assign o_result.slverr = i_apb.pslverr;

endmodule

// File: source/axi2apb_bridge.sv
`timescale 1ns/1ps

module axi2apb_bridge import axi2apb_pkg::*; #(
    parameter int ID_WIDTH = 8
) (
    input  logic                aclk,
    input  logic                aresetn,
    // AR
    input  logic                i_ar_valid,
    input  axi_addr_t           i_ar,
    input  logic [ID_WIDTH-1:0] i_ar_id,
    output logic                o_ar_ready,
    // R
    output logic                o_r_valid,
    output axi_r_t              o_r,
    output logic [ID_WIDTH-1:0] o_r_id,
    input  logic                i_r_ready,
    // AW
    input  logic                i_aw_valid,
    input  axi_addr_t           i_aw,
    input  logic [ID_WIDTH-1:0] i_aw_id,
    output logic                o_aw_ready,
    // W
    input  logic                i_w_valid,
    input  axi_w_t              i_w,
    output logic                o_w_ready,
    // B
    output logic                o_b_valid,
    output axi_resp_e           o_b_resp,
    output logic [ID_WIDTH-1:0] o_b_id,
    input  logic                i_b_ready,
    // APB master
    output apb_req_t            o_apb,
    input  apb_rsp_t            i_apb
);

    logic        rd_cmd_valid;
    apb_cmd_t    rd_cmd;
    logic        wr_cmd_valid;
    apb_cmd_t    wr_cmd;
    logic        rd_done;
    logic        wr_done;
    apb_result_t result;

    axi_read_engine #(
        .ID_WIDTH    (ID_WIDTH)
    ) u_read_engine (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_ar_valid  (i_ar_valid),
        .i_ar        (i_ar),
        .i_ar_id     (i_ar_id),
        .o_ar_ready  (o_ar_ready),
        .o_r_valid   (o_r_valid),
        .o_r         (o_r),
        .o_r_id      (o_r_id),
        .i_r_ready   (i_r_ready),
        .o_cmd_valid (rd_cmd_valid),
        .o_cmd       (rd_cmd),
        .i_rd_done   (rd_done),
        .i_result    (result)
    );

    axi_write_engine #(
        .ID_WIDTH    (ID_WIDTH)
    ) u_write_engine (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_aw_valid  (i_aw_valid),
        .i_aw        (i_aw),
        .i_aw_id     (i_aw_id),
        .o_aw_ready  (o_aw_ready),
        .i_w_valid   (i_w_valid),
        .i_w         (i_w),
        .o_w_ready   (o_w_ready),
        .o_b_valid   (o_b_valid),
        .o_b_resp    (o_b_resp),
        .o_b_id      (o_b_id),
        .i_b_ready   (i_b_ready),
        .o_cmd_valid (wr_cmd_valid),
        .o_cmd       (wr_cmd),
        .i_wr_done   (wr_done),
        .i_result    (result)
    );

    apb_sequencer u_apb_sequencer (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_rd_cmd_valid (rd_cmd_valid),
        .i_rd_cmd       (rd_cmd),
        .i_wr_cmd_valid (wr_cmd_valid),
        .i_wr_cmd       (wr_cmd),
        .o_apb          (o_apb),
        .i_apb          (i_apb),
        .o_rd_done      (rd_done),
        .o_wr_done      (wr_done),
        .o_result       (result)
    );

endmodule

// File: tests/apb_slave_model.sv
`timescale 1ns/1ps

module apb_slave_model import axi2apb_pkg::*; (
    input  logic     aclk,
    input  logic     aresetn,
    input  apb_req_t i_req,
    output apb_rsp_t o_rsp
);

    localparam int WORDS = 4096;

    logic [DATA_W-1:0] mem [WORDS];
    logic [WORDS-1:0]  written;
    logic [31:0]       lcg;
    logic [1:0]        wait_cnt;
    logic [11:0]       index;
    logic              err_region;
    logic              access_done;
    logic [DATA_W-1:0] stored;
    logic [DATA_W-1:0] merged;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign index       = i_req.paddr[13:2];
    // Bit 12 selects the error region
    assign err_region  = i_req.paddr[12];
    assign access_done = i_req.psel && i_req.penable && (wait_cnt == 2'd0);
    // Words never written read as zero
    assign stored      = written[index] ? mem[index] : '0;

    always_comb begin
        merged = stored;
        for (int i = 0; i < STRB_W; i++) begin
            if (i_req.pstrb[i]) begin
                merged[8*i +: 8] = i_req.pwdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lcg      <= 32'h9b973518;
            wait_cnt <= 2'd0;
            written  <= '0;
        end else begin
            if (i_req.psel && !i_req.penable) begin
                // 0 to 3 wait states per transfer
                lcg      <= next_random(lcg);
                wait_cnt <= lcg[29:28];
            end else if (i_req.psel && i_req.penable && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            if (access_done && i_req.pwrite && !err_region) begin
                written[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (access_done && i_req.pwrite && !err_region) begin
            mem[index] <= merged;
        end
    end

    assign o_rsp.pready  = access_done;
    assign o_rsp.pslverr = access_done && err_region;
    assign o_rsp.prdata  = err_region ? '0 : stored;

endmodule

// File: tests/tb_axi2apb.sv
`timescale 1ns/1ps

module tb_axi2apb import axi2apb_pkg::*; ();

    localparam int    ID_WIDTH   = 8;
    localparam int    CLK_PERIOD = 100;
    localparam string STIM_FILE  = "tests/axi2apb_stim.txt";

    typedef struct packed {
        logic [7:0]          kind;
        logic [ID_WIDTH-1:0] id;
        logic [ADDR_W-1:0]   addr;
        logic [LEN_W-1:0]    len;
        logic [DATA_W-1:0]   data;
        logic [STRB_W-1:0]   strb;
        axi_resp_e           resp;
        logic                pair;
    } stim_rec_t;

    logic                aclk;
    logic                aresetn;
    logic                ar_valid;
    axi_addr_t           ar;
    logic [ID_WIDTH-1:0] ar_id;
    logic                ar_ready;
    logic                r_valid;
    axi_r_t              r_beat;
    logic [ID_WIDTH-1:0] r_id;
    logic                r_ready;
    logic                aw_valid;
    axi_addr_t           aw;
    logic [ID_WIDTH-1:0] aw_id;
    logic                aw_ready;
    logic                w_valid;
    axi_w_t              w_beat;
    logic                w_ready;
    logic                b_valid;
    axi_resp_e           b_resp;
    logic [ID_WIDTH-1:0] b_id;
    logic                b_ready;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;

    stim_rec_t         recs[$];
    logic [DATA_W-1:0] model [logic [ADDR_W-1:0]];
    logic [31:0]       rand_state;
    logic [2:0]        wr_prot;
    logic [2:0]        rd_prot;
    int                watchdog_cycles;
    int                r_errors;
    int                b_errors;
    int                apb_errors;
    int                other_errors;

    axi2apb_bridge #(
        .ID_WIDTH   (ID_WIDTH)
    ) dut0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_ar_valid (ar_valid),
        .i_ar       (ar),
        .i_ar_id    (ar_id),
        .o_ar_ready (ar_ready),
        .o_r_valid  (r_valid),
        .o_r        (r_beat),
        .o_r_id     (r_id),
        .i_r_ready  (r_ready),
        .i_aw_valid (aw_valid),
        .i_aw       (aw),
        .i_aw_id    (aw_id),
        .o_aw_ready (aw_ready),
        .i_w_valid  (w_valid),
        .i_w        (w_beat),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .o_b_resp   (b_resp),
        .o_b_id     (b_id),
        .i_b_ready  (b_ready),
        .o_apb      (apb_req),
        .i_apb      (apb_rsp)
    );

    apb_slave_model slave0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_req   (apb_req),
        .o_rsp   (apb_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic logic random_bit();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state[31];
    endfunction

    // Full-width beats stepping up from the word-aligned start
    function automatic logic [ADDR_W-1:0] beat_addr(input logic [ADDR_W-1:0] base, input int beat);
        return (base & ~ADDR_W'(STRB_W - 1)) + ADDR_W'(beat * STRB_W);
    endfunction

    function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] a);
        if (model.exists(a)) begin
            return model[a];
        end
        return '0;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
        return a[12] ? '0 : model_word(a);
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] a,
                                        input logic [DATA_W-1:0] data,
                                        input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] word;
        word = model_word(a);
        for (int j = 0; j < STRB_W; j++) begin
            if (strb[j]) begin
                word[8*j +: 8] = data[8*j +: 8];
            end
        end
        model[a] = word;
    endfunction

    task automatic check_r(input axi_r_t got, input logic [ID_WIDTH-1:0] got_id,
                           input axi_r_t exp, input logic [ID_WIDTH-1:0] exp_id);
        if (got !== exp || got_id !== exp_id) begin
            r_errors++;
            $display("** Error at %0t: R beat data %h resp %0h last %b id %h, expected %h %0h %b %h",
                     $time, got.data, got.resp, got.last, got_id,
                     exp.data, exp.resp, exp.last, exp_id);
        end
    endtask

    task automatic check_b(input axi_resp_e got, input logic [ID_WIDTH-1:0] got_id,
                           input axi_resp_e exp, input logic [ID_WIDTH-1:0] exp_id);
        if (got !== exp || got_id !== exp_id) begin
            b_errors++;
            $display("** Error at %0t: B resp %0h id %h, expected resp %0h id %h",
                     $time, got, got_id, exp, exp_id);
        end
    endtask

    task automatic check_prot(input apb_req_t got, input logic [2:0] exp);
        if (got.pprot !== exp) begin
            apb_errors++;
            $display("** Error at %0t: APB pwrite %b paddr %h pprot %0h, expected pprot %0h",
                     $time, got.pwrite, got.paddr, got.pprot, exp);
        end
    endtask

    // Each APB access carries the prot of the burst it belongs to
    always @(posedge aclk) begin
        if (aresetn && apb_req.psel && apb_req.penable) begin
            check_prot(apb_req, apb_req.pwrite ? wr_prot : rd_prot);
        end
    end

    task automatic run_write(input stim_rec_t rec);
        axi_w_t     beat;
        logic [ADDR_W-1:0] a;
        logic       done;
        wr_prot = rec.id[2:0];
        @(posedge aclk);
        aw_valid <= 1'b1;
        aw       <= '{addr: rec.addr, len: rec.len, prot: wr_prot};
        aw_id    <= rec.id;
        do @(posedge aclk); while (!aw_ready);
        aw_valid <= 1'b0;
        for (int i = 0; i <= int'(rec.len); i++) begin
            beat.data = rec.data + DATA_W'(i);
            beat.strb = rec.strb;
            beat.last = (i == int'(rec.len));
            w_valid <= 1'b1;
            w_beat  <= beat;
            do @(posedge aclk); while (!w_ready);
            a = beat_addr(rec.addr, i);
            if (!a[12]) begin
                model_write(a, beat.data, beat.strb);
            end
        end
        w_valid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge aclk);
            if (b_ready && b_valid) begin
                check_b(b_resp, b_id, rec.resp, rec.id);
                done = 1'b1;
            end else begin
                b_ready <= random_bit();
            end
        end
        b_ready <= 1'b0;
    endtask

    task automatic run_read(input stim_rec_t rec);
        axi_r_t exp;
        int     beat;
        rd_prot = ~rec.id[2:0];
        @(posedge aclk);
        ar_valid <= 1'b1;
        ar       <= '{addr: rec.addr, len: rec.len, prot: rd_prot};
        ar_id    <= rec.id;
        do @(posedge aclk); while (!ar_ready);
        ar_valid <= 1'b0;
        beat = 0;
        while (beat <= int'(rec.len)) begin
            @(posedge aclk);
            if (r_ready && r_valid) begin
                exp.data = expected_read(beat_addr(rec.addr, beat));
                exp.resp = rec.resp;
                exp.last = (beat == int'(rec.len));
                check_r(r_beat, r_id, exp, rec.id);
                beat++;
            end
            // Random R back-pressure
            r_ready <= random_bit();
        end
        r_ready <= 1'b0;
    endtask

    task automatic run_all();
        stim_rec_t wr_rec;
        stim_rec_t rd_rec;
        int        k;
        k = 0;
        while (k < recs.size()) begin
            if (recs[k].kind == "W" && recs[k].pair && k + 1 < recs.size()
                && recs[k + 1].kind == "R") begin
                // AW and AR start on the same edge
                wr_rec = recs[k];
                rd_rec = recs[k + 1];
                fork
                    run_write(wr_rec);
                    run_read(rd_rec);
                join
                k += 2;
            end else begin
                if (recs[k].kind == "W") begin
                    run_write(recs[k]);
                end else if (recs[k].kind == "R") begin
                    run_read(recs[k]);
                end else begin
                    other_errors++;
                    $display("Stimulus record %0d has an unknown kind %c", k, recs[k].kind);
                end
                k += 1;
            end
        end
    endtask

    task automatic load_stimulus(output logic ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] id;
        logic [31:0] addr;
        logic [31:0] len;
        logic [31:0] data;
        logic [31:0] strb;
        logic [31:0] resp;
        logic [31:0] pair;
        stim_rec_t   rec;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h %h %h",
                                kind, id, addr, len, data, strb, resp, pair);
                    if (n == 8) begin
                        rec.kind = kind;
                        rec.id   = id[ID_WIDTH-1:0];
                        rec.addr = addr;
                        rec.len  = len[LEN_W-1:0];
                        rec.data = data;
                        rec.strb = strb[STRB_W-1:0];
                        rec.resp = axi_resp_e'(resp[1:0]);
                        rec.pair = pair[0];
                        recs.push_back(rec);
                    end
                end
            end
            $fclose(fd);
            ok = (recs.size() > 0);
        end
    endtask

    initial begin
        logic loaded;
        int   total_beats;
        aresetn      = 1'b0;
        ar_valid     = 1'b0;
        ar           = '0;
        ar_id        = '0;
        r_ready      = 1'b0;
        aw_valid     = 1'b0;
        aw           = '0;
        aw_id        = '0;
        w_valid      = 1'b0;
        w_beat       = '0;
        b_ready      = 1'b0;
        rand_state   = 32'h9b973518;
        wr_prot      = '0;
        rd_prot      = '0;
        r_errors     = 0;
        b_errors     = 0;
        apb_errors   = 0;
        other_errors = 0;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("Could not read any record from %s", STIM_FILE);
            $display("Testbench failed");
            $finish;
        end else begin
            total_beats = 0;
            foreach (recs[k]) begin
                total_beats += int'(recs[k].len) + 1;
            end
            // 20 cycles per beat, plus the reset cycles
            watchdog_cycles = total_beats * 20 + 4;
            repeat (4) @(posedge aclk);
            aresetn <= 1'b1;
            run_all();
            $display("Error counts: R %0d, B %0d, APB %0d, other %0d",
                     r_errors, b_errors, apb_errors, other_errors);
            if (r_errors + b_errors + apb_errors + other_errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Timeout: the transfers did not finish within %0d cycles", watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: tests/axi2apb_stim.txt
# kind id addr len data strb resp pair, all fields after kind in hex
# resp 0 is OKAY and 2 is SLVERR, pair 1 starts the write together with the next read
W 01 00000100 00 11223344 f 0 0
R 02 00000100 00 00000000 0 0 0
W 03 00000200 07 a0000000 f 0 0
R 04 00000200 07 00000000 0 0 0
W 05 00001040 03 deadbeef f 2 0
R 06 00001040 03 00000000 0 2 0
W 07 00000300 00 cafef00d f 0 0
W 08 00000300 00 55667788 5 0 0
R 09 00000300 00 00000000 0 0 0
W 0a 00000400 0f 01000000 f 0 0
R 0b 00000400 0f 00000000 0 0 0
W 0c 00000500 03 77000000 f 0 1
R 0d 00000200 03 00000000 0 0 0
R 0e 00000500 03 00000000 0 0 0
W 0f 00000800 ff 10000000 f 0 0
R 10 00000800 ff 00000000 0 0 0
W 11 00000ffc 01 00ff00ff f 2 0
R 12 00000ffc 00 00000000 0 0 0

// File: src.f
source/axi2apb_pkg.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/apb_sequencer.sv
source/axi2apb_bridge.sv
tests/apb_slave_model.sv
tests/tb_axi2apb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_axi2apb
RTL_TOP    := axi2apb_bridge
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
